//--- files.f
+incdir+include
rtl/id_pkg.sv
rtl/id_decoder.sv
rtl/id_operand_mux.sv
rtl/id_fsm.sv
rtl/mac_sequencer.sv
rtl/id_stage_top.sv
verification/tb_id_stage.sv

//--- include/id_params.svh
////////////////////////////////////////////////////////////////////////////
// ID stage constants
// Datapath width, register address width and PC step
////////////////////////////////////////////////////////////////////////////

`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Data and PC width
`define ID_XLEN 32

// Register file address width, 32 entries
`define ID_REG_AW 5

// Sequential PC step, no compressed support
`define ID_PC_INCR 4

`endif

//--- rtl/id_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Instruction decoder
// Maps one instruction word to control, immediates and register addresses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "id_params.svh"

module id_decoder import id_pkg::*; (
  input  instr_u                  instr_i,
  input  logic                    instr_valid_i,
  output dec_ctrl_t               ctrl_o,
  output logic [`ID_XLEN-1:0]     imm_i_o,
  output logic [`ID_XLEN-1:0]     imm_s_o,
  output logic [`ID_XLEN-1:0]     imm_b_o,
  output logic [`ID_XLEN-1:0]     imm_u_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_b_o,
  output logic [`ID_REG_AW-1:0]   rf_waddr_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Immediates and register fields
  ////////////////////////////////////////////////////////////////////////////

  assign imm_i_o = {{(`ID_XLEN-12){instr_i.i_type.imm_11_0[11]}}, instr_i.i_type.imm_11_0};
  // S layout shares bit positions with funct7 and rd of the R view
  assign imm_s_o = {{(`ID_XLEN-12){instr_i.r_type.funct7[6]}},
                    instr_i.r_type.funct7, instr_i.r_type.rd};
  assign imm_b_o = {{(`ID_XLEN-12){instr_i.b_type.imm_12}}, instr_i.b_type.imm_11,
                    instr_i.b_type.imm_10_5, instr_i.b_type.imm_4_1, 1'b0};
  assign imm_u_o = {instr_i.u_type.imm_31_12, 12'b0};

  assign rf_raddr_a_o = instr_i.r_type.rs1;
  assign rf_raddr_b_o = instr_i.r_type.rs2;
  assign rf_waddr_o   = instr_i.r_type.rd;

  ////////////////////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults: register-register add, nothing enabled
    ctrl_o          = '0;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.md_op    = MD_OP_MUL;
    ctrl_o.op_a_sel = OP_A_REG_A;
    ctrl_o.op_b_sel = OP_B_REG_B;
    ctrl_o.imm_sel  = IMM_I;

    unique case (instr_i.r_type.opcode)
      OPC_OP: begin
        ctrl_o.rf_we = 1'b1;
        if (instr_i.r_type.funct7 == 7'h00) begin
          unique case (instr_i.r_type.funct3)
            3'b000:  ctrl_o.alu_op = ALU_ADD;
            3'b010:  ctrl_o.alu_op = ALU_SLT;
            3'b011:  ctrl_o.alu_op = ALU_SLTU;
            3'b100:  ctrl_o.alu_op = ALU_XOR;
            3'b110:  ctrl_o.alu_op = ALU_OR;
            3'b111:  ctrl_o.alu_op = ALU_AND;
            default: ctrl_o.illegal = 1'b1;
          endcase
        end else if (instr_i.r_type.funct7 == 7'h20 && instr_i.r_type.funct3 == 3'b000) begin
          ctrl_o.alu_op = ALU_SUB;
        end else if (instr_i.r_type.funct7 == 7'h01 && instr_i.r_type.funct3 == 3'b000) begin
          // MUL, low word of the product
          ctrl_o.mult_en = 1'b1;
        end else begin
          ctrl_o.illegal = 1'b1;
        end
      end

      OPC_OP_IMM: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        unique case (instr_i.i_type.funct3)
          3'b000:  ctrl_o.alu_op = ALU_ADD;
          3'b010:  ctrl_o.alu_op = ALU_SLT;
          3'b011:  ctrl_o.alu_op = ALU_SLTU;
          3'b100:  ctrl_o.alu_op = ALU_XOR;
          3'b110:  ctrl_o.alu_op = ALU_OR;
          3'b111:  ctrl_o.alu_op = ALU_AND;
          // Shifts are outside the subset
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = (instr_i.u_type.opcode == OPC_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end

      OPC_BRANCH: begin
        // Compare rs1 against rs2, target offset on the B immediate
        ctrl_o.branch  = 1'b1;
        ctrl_o.imm_sel = IMM_B;
        unique case (instr_i.b_type.funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      OPC_CUSTOM0: begin
        // MAC, rd += rs1 * rs2, second phase is an ALU add
        if (instr_i.r_type.funct7 == 7'h00 && instr_i.r_type.funct3 == 3'b000) begin
          ctrl_o.mac_en = 1'b1;
          ctrl_o.rf_we  = 1'b1;
        end else begin
          ctrl_o.illegal = 1'b1;
        end
      end

      default: ctrl_o.illegal = 1'b1;
    endcase

    // Illegal words do nothing
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we   = 1'b0;
      ctrl_o.mult_en = 1'b0;
      ctrl_o.mac_en  = 1'b0;
      ctrl_o.branch  = 1'b0;
    end
    ctrl_o.illegal = ctrl_o.illegal & instr_valid_i;
  end

endmodule

//--- rtl/id_fsm.sv
////////////////////////////////////////////////////////////////////////////
// ID state machine
// First-cycle/multi-cycle tracking, stalls, completion, write gating
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module id_fsm import id_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      instr_valid_i,
  input  dec_ctrl_t ctrl_i,
  input  logic      ex_valid_i,
  input  logic      branch_decision_i,
  input  logic      mac_phase2_i,
  output logic      instr_done_o,
  output logic      rf_we_o,
  output logic      pc_set_o,
  output logic      mult_phase_o
);

  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

  id_fsm_e state_q, state_d;
  logic    mult_op;
  logic    stall_mult;
  logic    stall_branch;
  logic    stall;
  logic    branch_set_d, branch_set_q;

  // Multiplier busy for MUL, and for MAC until its add phase
  assign mult_op = ctrl_i.mult_en | (ctrl_i.mac_en & ~mac_phase2_i);

  always_comb begin
    stall_mult   = 1'b0;
    stall_branch = 1'b0;
    branch_set_d = 1'b0;

    if (instr_valid_i) begin
      // MAC always stalls out of phase one, the add follows
      if (mult_op) begin
        stall_mult = ~ex_valid_i | ctrl_i.mac_en;
      end

      unique case (state_q)
        FIRST_CYCLE: begin
          // Taken branch holds one cycle, PC set comes out of the flop
          if (ctrl_i.branch) begin
            stall_branch = branch_decision_i;
            branch_set_d = branch_decision_i;
          end
        end
        MULTI_CYCLE: begin
          // Second cycle of a branch or a waiting multiply
          stall_branch = 1'b0;
        end
        default: stall_branch = 1'b0;
      endcase
    end
  end

  assign stall   = stall_mult | stall_branch;
  assign state_d = stall ? MULTI_CYCLE : FIRST_CYCLE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FIRST_CYCLE;
      branch_set_q <= 1'b0;
    end else begin
      if (instr_valid_i) begin
        state_q <= state_d;
      end
      branch_set_q <= branch_set_d;
    end
  end

  assign instr_done_o = instr_valid_i & ~stall;
  // No write while the multiplier result is pending
  assign rf_we_o      = instr_valid_i & ctrl_i.rf_we & ~stall_mult;
  assign mult_phase_o = instr_valid_i & mult_op;
  assign pc_set_o     = branch_set_q;

endmodule

//--- rtl/id_operand_mux.sv
////////////////////////////////////////////////////////////////////////////
// ALU operand selection
// Picks the immediate and builds operands A and B for the execute request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "id_params.svh"

module id_operand_mux import id_pkg::*; (
  input  dec_ctrl_t             ctrl_i,
  input  logic [`ID_XLEN-1:0]   imm_i_i,
  input  logic [`ID_XLEN-1:0]   imm_s_i,
  input  logic [`ID_XLEN-1:0]   imm_b_i,
  input  logic [`ID_XLEN-1:0]   imm_u_i,
  input  logic [`ID_XLEN-1:0]   pc_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]   rf_rdata_b_i,
  output logic [`ID_XLEN-1:0]   operand_a_o,
  output logic [`ID_XLEN-1:0]   operand_b_o
);

  logic [`ID_XLEN-1:0] imm;

  // Immediate for operand B
  always_comb begin
    unique case (ctrl_i.imm_sel)
      IMM_I:       imm = imm_i_i;
      IMM_S:       imm = imm_s_i;
      IMM_B:       imm = imm_b_i;
      IMM_U:       imm = imm_u_i;
      IMM_INCR_PC: imm = `ID_XLEN'(`ID_PC_INCR);
      default:     imm = `ID_XLEN'(`ID_PC_INCR);
    endcase
  end

  // Operand A, register, PC for AUIPC or zero for LUI
  always_comb begin
    unique case (ctrl_i.op_a_sel)
      OP_A_REG_A:  operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: operand_a_o = pc_i;
      OP_A_ZERO:   operand_a_o = '0;
      default:     operand_a_o = rf_rdata_a_i;
    endcase
  end

  // Operand B
  assign operand_b_o = (ctrl_i.op_b_sel == OP_B_IMM) ? imm : rf_rdata_b_i;

endmodule

//--- rtl/id_pkg.sv
////////////////////////////////////////////////////////////////////////////
// ID stage types
// Opcodes, operator and selector encodings, instruction views and the
// structs passed between the decode blocks and to execute/writeback
////////////////////////////////////////////////////////////////////////////

`include "id_params.svh"

package id_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP      = 7'h33,
    OPC_OP_IMM  = 7'h13,
    OPC_LUI     = 7'h37,
    OPC_AUIPC   = 7'h17,
    OPC_BRANCH  = 7'h63,
    OPC_CUSTOM0 = 7'h0b
  } opcode_e;

  // ALU operators, the last six are branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Multiplier operator, low word only
  typedef enum logic [1:0] {
    MD_OP_MUL = 2'b00
  } md_op_e;

  typedef enum logic [1:0] {
    OP_A_REG_A, OP_A_CURRPC, OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B, OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_B, IMM_U, IMM_INCR_PC
  } imm_sel_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction format views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_i_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } instr_u_t;

  // One fetched word, read through the view matching its opcode
  typedef union packed {
    instr_r_t r_type;
    instr_i_t i_type;
    instr_b_t b_type;
    instr_u_t u_type;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e   alu_op;
    md_op_e    md_op;
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    imm_sel_e  imm_sel;
    logic      rf_we;
    logic      mult_en;
    logic      mac_en;
    logic      branch;
    logic      illegal;
  } dec_ctrl_t;

  // Request towards the external execute unit
  typedef struct packed {
    alu_op_e                alu_op;
    logic [`ID_XLEN-1:0]    operand_a;
    logic [`ID_XLEN-1:0]    operand_b;
    logic                   mult_en;
    md_op_e                 md_op;
  } ex_req_t;

  // Register file write port
  typedef struct packed {
    logic                   we;
    logic [`ID_REG_AW-1:0]  waddr;
    logic [`ID_XLEN-1:0]    wdata;
  } wb_t;

endpackage

//--- rtl/id_stage_top.sv
////////////////////////////////////////////////////////////////////////////
// ID stage top
// Decoder, operand mux, state machine and MAC sequencer with the execute
// request and register writeback
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "id_params.svh"

module id_stage_top import id_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Fetch side
  input  logic                    instr_valid_i,
  input  instr_u                  instr_i,
  input  logic [`ID_XLEN-1:0]     pc_i,
  output logic                    id_in_ready_o,
  output logic                    instr_done_o,
  output logic                    illegal_insn_o,
  output logic                    pc_set_o,
  // Execute side
  input  logic                    branch_decision_i,
  input  logic                    ex_valid_i,
  input  logic [`ID_XLEN-1:0]     result_ex_i,
  output ex_req_t                 ex_req_o,
  // Register file
  output logic [`ID_REG_AW-1:0]   rf_raddr_a_o,
  output logic [`ID_REG_AW-1:0]   rf_raddr_b_o,
  input  logic [`ID_XLEN-1:0]     rf_rdata_a_i,
  input  logic [`ID_XLEN-1:0]     rf_rdata_b_i,
  output wb_t                     wb_o
);

  dec_ctrl_t              ctrl;
  logic [`ID_XLEN-1:0]    imm_i, imm_s, imm_b, imm_u;
  logic [`ID_REG_AW-1:0]  raddr_b;
  logic [`ID_REG_AW-1:0]  rd;
  logic [`ID_XLEN-1:0]    operand_a, operand_b;
  logic [`ID_XLEN-1:0]    acc, prod;
  logic                   instr_executing;
  logic                   instr_done;
  logic                   rf_we;
  logic                   mult_phase;
  logic                   mac_phase2;

  id_decoder u_decoder (
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .ctrl_o        (ctrl),
    .imm_i_o       (imm_i),
    .imm_s_o       (imm_s),
    .imm_b_o       (imm_b),
    .imm_u_o       (imm_u),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (raddr_b),
    .rf_waddr_o    (rd)
  );

  id_operand_mux u_operand_mux (
    .ctrl_i       (ctrl),
    .imm_i_i      (imm_i),
    .imm_s_i      (imm_s),
    .imm_b_i      (imm_b),
    .imm_u_i      (imm_u),
    .pc_i         (pc_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .operand_a_o  (operand_a),
    .operand_b_o  (operand_b)
  );

  id_fsm u_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .ctrl_i            (ctrl),
    .ex_valid_i        (ex_valid_i),
    .branch_decision_i (branch_decision_i),
    .mac_phase2_i      (mac_phase2),
    .instr_done_o      (instr_done),
    .rf_we_o           (rf_we),
    .pc_set_o          (pc_set_o),
    .mult_phase_o      (mult_phase)
  );

  // Illegal words never start execution
  assign instr_executing = instr_valid_i & ~ctrl.illegal;

  mac_sequencer u_mac_sequencer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_i            (ctrl),
    .instr_executing_i (instr_executing),
    .ex_valid_i        (ex_valid_i),
    .rd_i              (rd),
    .rf_rdata_rd_i     (rf_rdata_b_i),
    .wb_i              (wb_o),
    .result_ex_i       (result_ex_i),
    .mac_phase2_o      (mac_phase2),
    .acc_o             (acc),
    .prod_o            (prod)
  );

  // Port B reads rd once the multiply no longer needs rs2
  assign rf_raddr_b_o = mac_phase2 ? rd : raddr_b;

  ////////////////////////////////////////////////////////////////////////////
  // Execute request
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ex_req_o.alu_op    = ctrl.alu_op;
    ex_req_o.operand_a = operand_a;
    ex_req_o.operand_b = operand_b;
    ex_req_o.mult_en   = mult_phase;
    ex_req_o.md_op     = ctrl.md_op;
    if (mac_phase2) begin
      // MAC add, accumulator plus saved product
      ex_req_o.alu_op    = ALU_ADD;
      ex_req_o.operand_a = acc;
      ex_req_o.operand_b = prod;
    end
  end

  // Writeback straight from the execute result
  assign wb_o.we    = rf_we;
  assign wb_o.waddr = rd;
  assign wb_o.wdata = result_ex_i;

  assign illegal_insn_o = ctrl.illegal;
  assign instr_done_o   = instr_done;
  assign id_in_ready_o  = instr_done;

endmodule

//--- rtl/mac_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// MAC sequencer
// Tracks multiply and add phases, holds the product and the forwarded
// accumulator for the add
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "id_params.svh"

module mac_sequencer import id_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dec_ctrl_t               ctrl_i,
  input  logic                    instr_executing_i,
  input  logic                    ex_valid_i,
  input  logic [`ID_REG_AW-1:0]   rd_i,
  input  logic [`ID_XLEN-1:0]     rf_rdata_rd_i,
  input  wb_t                     wb_i,
  input  logic [`ID_XLEN-1:0]     result_ex_i,
  output logic                    mac_phase2_o,
  output logic [`ID_XLEN-1:0]     acc_o,
  output logic [`ID_XLEN-1:0]     prod_o
);

  logic                   mac_active;
  logic                   mac_first;
  logic                   phase1_done;
  logic                   busy_q;
  logic                   phase2_q;
  logic                   fwd_cur;
  logic                   fwd_prev;
  logic                   fwd_hit_q;
  logic [`ID_XLEN-1:0]    fwd_data_q;
  logic [`ID_XLEN-1:0]    prod_q;
  // Own copy of last cycle's writeback
  logic                   wb_we_q;
  logic [`ID_REG_AW-1:0]  wb_waddr_q;
  logic [`ID_XLEN-1:0]    wb_wdata_q;

  assign mac_active  = instr_executing_i & ctrl_i.mac_en;
  assign mac_first   = mac_active & ~busy_q;
  assign phase1_done = mac_active & ~phase2_q & ex_valid_i;

  // Writeback hits on rd, x0 never forwards
  assign fwd_cur  = wb_i.we & (wb_i.waddr == rd_i) & (rd_i != '0);
  assign fwd_prev = wb_we_q & (wb_waddr_q == rd_i) & (rd_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      phase2_q  <= 1'b0;
      wb_we_q   <= 1'b0;
      fwd_hit_q <= 1'b0;
    end else begin
      wb_we_q  <= wb_i.we;
      // Busy from the second MAC cycle until the add is done
      busy_q   <= mac_active & ~phase2_q;
      // Add phase lasts exactly one cycle
      phase2_q <= phase1_done;
      if (mac_first) begin
        fwd_hit_q <= fwd_cur | fwd_prev;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    wb_waddr_q <= wb_i.waddr;
    wb_wdata_q <= wb_i.wdata;
    // Current writeback wins over the older one
    if (mac_first) begin
      fwd_data_q <= fwd_cur ? wb_i.wdata : wb_wdata_q;
    end
    if (phase1_done) begin
      prod_q <= result_ex_i;
    end
  end

  // Without a forward hit, rd comes from the register file in phase two
  assign acc_o        = fwd_hit_q ? fwd_data_q : rf_rdata_rd_i;
  assign prod_o       = prod_q;
  assign mac_phase2_o = phase2_q;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f \
  --top-module tb_id_stage -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log
if grep -q "TB PASSED" sim.log; then
  exit 0
fi
exit 1

//--- verification/tb_id_stage.sv
////////////////////////////////////////////////////////////////////////////
// ID stage testbench
// Register file and execute models around the DUT, directed and random
// instruction streams, checks done by assertions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "id_params.svh"

module tb_id_stage import id_pkg::*; ();

  localparam int MAX_INSTR = 64;
  localparam int LIMIT     = 2 * MAX_INSTR * 8;

  logic clk_i, rst_ni, instr_valid_i, id_in_ready_o, instr_done_o;
  logic illegal_insn_o, pc_set_o, branch_decision_i, ex_valid_i;
  instr_u instr_i;
  logic [31:0] pc_i, result_ex_i, rf_rdata_a_i, rf_rdata_b_i;
  logic [4:0] rf_raddr_a_o, rf_raddr_b_o;
  ex_req_t ex_req_o, prev_req;
  wb_t wb_o;

  logic [31:0] regs [32];
  logic [31:0] shadow [32];
  logic [31:0] rnd_state = 32'd75108;
  logic [31:0] exp_data, exp_a, exp_b, cur_pc;
  logic [4:0]  exp_rd;
  logic        exp_we, exp_illegal, exp_taken, chk_ops, exp_mac, wait_q;
  logic        mul_req_q, mul_ready_q;
  int          exp_cycles, cyc_q, cycle_count, errors, checks, mul_cnt, mul_delay;

  id_stage_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  // External execute unit, ALU side
  function automatic logic [31:0] exec_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: return {31'b0, a < b};
      ALU_EQ:   return {31'b0, a == b};
      ALU_NE:   return {31'b0, a != b};
      ALU_LT:   return {31'b0, $signed(a) < $signed(b)};
      ALU_GE:   return {31'b0, $signed(a) >= $signed(b)};
      ALU_LTU:  return {31'b0, a < b};
      default:  return {31'b0, a >= b};
    endcase
  endfunction

  // Register file reads are combinational
  assign rf_rdata_a_i = regs[rf_raddr_a_o];
  assign rf_rdata_b_i = regs[rf_raddr_b_o];

  // Execute model, multiply answers after mul_delay waiting cycles
  always_comb begin
    if (ex_req_o.mult_en) begin
      ex_valid_i  = instr_valid_i & (mul_cnt == mul_delay);
      result_ex_i = ex_req_o.operand_a * ex_req_o.operand_b;
      // No usable product on the bus before the answer
      if (!ex_valid_i) result_ex_i = ~result_ex_i;
    end else begin
      result_ex_i = exec_alu(ex_req_o.alu_op, ex_req_o.operand_a, ex_req_o.operand_b);
      ex_valid_i  = instr_valid_i;
    end
    branch_decision_i = instr_valid_i & (ex_req_o.alu_op >= ALU_EQ) & result_ex_i[0];
  end

  always @(negedge clk_i) begin
    if (mul_req_q && !mul_ready_q) begin
      mul_cnt <= mul_cnt + 1;
    end else begin
      mul_cnt   <= 0;
      mul_delay <= 1 + int'(next_rand() % 4);
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("Error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // Redirecting branches never write
  assert property (@(posedge clk_i) disable iff (!rst_ni) pc_set_o |-> !wb_o.we)
    else begin
      errors++;
      $display("A branch redirect came with a register write");
    end

  // Monitor, register file write and multiply sampling
  always @(posedge clk_i) begin
    int   cur;
    logic done_exp;
    if (rst_ni) begin
      mul_req_q   <= ex_req_o.mult_en;
      mul_ready_q <= ex_valid_i;
      if (wb_o.we && wb_o.waddr != 0) regs[wb_o.waddr] <= wb_o.wdata;
      if (!instr_valid_i) begin
        check_value("idle", 0,
                    {pc_set_o, wb_o.we, ex_req_o.mult_en, id_in_ready_o, instr_done_o});
      end else begin
        cur = cyc_q + 1;
        // Completion from the fixed latency or from the execute model
        if (exp_cycles != 0) begin
          done_exp = (cur == exp_cycles);
        end else if (exp_mac) begin
          // Add cycle follows the cycle the product was handed over
          done_exp = (cur > 1) && mul_req_q && mul_ready_q;
        end else begin
          done_exp = ex_valid_i;
        end
        check_value("id_in_ready", done_exp, id_in_ready_o);
        check_value("instr_done", done_exp, instr_done_o);
        check_value("illegal", exp_illegal, illegal_insn_o);
        check_value("pc_set", exp_taken && cur == 2, pc_set_o);
        if (chk_ops && cur == 1) begin
          check_value("operand_a", exp_a, ex_req_o.operand_a);
          check_value("operand_b", exp_b, ex_req_o.operand_b);
        end
        if (ex_req_o.mult_en) check_value("md_op", MD_OP_MUL, ex_req_o.md_op);
        if (wait_q && ex_req_o.mult_en) check_value("mul_req_stable", 1, ex_req_o == prev_req);
        if (id_in_ready_o) begin
          check_value("wb_we", exp_we, wb_o.we);
          if (exp_we) begin
            check_value("wb_waddr", exp_rd, wb_o.waddr);
            check_value("wb_wdata", exp_data, wb_o.wdata);
          end
        end else begin
          check_value("wb_we_early", 0, wb_o.we);
        end
        cyc_q = id_in_ready_o ? 0 : cur;
      end
      prev_req = ex_req_o;
      wait_q   = ex_req_o.mult_en & ~ex_valid_i;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > LIMIT) begin
      $display("Timeout: the run did not end within %0d cycles", LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference decode and stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] ref_alu(logic [2:0] f3, logic sub, logic [31:0] a,
                                          logic [31:0] b);
    case (f3)
      3'b000:  return sub ? a - b : a + b;
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] off, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  task automatic issue(input logic [31:0] w);
    logic [31:0] a, b, imm_i, imm_u;
    logic        f3_ok;
    a     = shadow[w[19:15]];
    b     = shadow[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    f3_ok = w[14:12] inside {3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
    @(negedge clk_i);
    {exp_we, exp_illegal, exp_taken, chk_ops, exp_mac} = 5'b00000;
    exp_cycles = 1;
    exp_rd     = w[11:7];
    case (w[6:0])
      7'h33: begin
        if ((w[31:25] == 7'h00 && f3_ok) || (w[31:25] == 7'h20 && w[14:12] == 0)) begin
          {exp_we, chk_ops} = 2'b11;
          exp_data = ref_alu(w[14:12], w[30], a, b);
          {exp_a, exp_b} = {a, b};
        end else if (w[31:25] == 7'h01 && w[14:12] == 0) begin
          {exp_we, exp_cycles} = {1'b1, 32'd0};
          exp_data = a * b;
        end else exp_illegal = 1'b1;
      end
      7'h13: begin
        if (f3_ok) begin
          {exp_we, chk_ops} = 2'b11;
          exp_data = ref_alu(w[14:12], 1'b0, a, imm_i);
          {exp_a, exp_b} = {a, imm_i};
        end else exp_illegal = 1'b1;
      end
      7'h37, 7'h17: begin
        {exp_we, chk_ops} = 2'b11;
        exp_a    = (w[6:0] == 7'h37) ? 32'd0 : cur_pc;
        exp_b    = imm_u;
        exp_data = exp_a + imm_u;
      end
      7'h63: begin
        if (w[14:12] inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7}) begin
          exp_taken  = ref_taken(w[14:12], a, b);
          exp_cycles = exp_taken ? 2 : 1;
        end else exp_illegal = 1'b1;
      end
      7'h0b: begin
        if (w[31:25] == 0 && w[14:12] == 0) begin
          {exp_we, exp_mac, exp_cycles} = {2'b11, 32'd0};
          exp_data = shadow[w[11:7]] + a * b;
        end else exp_illegal = 1'b1;
      end
      default: exp_illegal = 1'b1;
    endcase
    instr_valid_i = 1'b1;
    instr_i       = w;
    pc_i          = cur_pc;
    do @(posedge clk_i); while (!id_in_ready_o);
    if (exp_we && w[11:7] != 0) shadow[w[11:7]] = exp_data;
    cur_pc = cur_pc + `ID_PC_INCR;
  endtask

  initial begin
    logic [31:0] r;
    logic [4:0]  rd, rs1, rs2;
    {instr_valid_i, rst_ni, pc_i, cur_pc, instr_i} = '0;
    {errors, checks, cycle_count, cyc_q, mul_cnt, wait_q} = '0;
    {mul_req_q, mul_ready_q} = 2'b00;
    mul_delay = 1;
    for (int i = 0; i < 32; i++) begin
      regs[i]   = '0;
      shadow[i] = '0;
    end
    repeat (3) @(posedge clk_i);
    @(negedge clk_i) rst_ni = 1'b1;
    // Idle cycles with nothing valid
    repeat (2) @(posedge clk_i);
    // Register setup
    issue(enc_i(12'd5, 0, 0, 1));
    issue(enc_i(12'hffd, 0, 0, 2));
    issue(enc_i(12'h7ff, 0, 0, 3));
    issue(enc_i(12'h800, 0, 0, 4));
    issue(enc_i(12'd100, 0, 0, 5));
    issue(enc_i(12'd7, 0, 0, 6));
    issue(enc_i(12'hfff, 0, 0, 7));
    // Register and immediate ALU ops
    issue(enc_r(0, 2, 1, 0, 8, 7'h33));
    issue(enc_r(7'h20, 2, 1, 0, 9, 7'h33));
    issue(enc_r(0, 1, 2, 2, 10, 7'h33));
    issue(enc_r(0, 1, 2, 3, 11, 7'h33));
    issue(enc_r(0, 7, 3, 4, 12, 7'h33));
    issue(enc_r(0, 4, 3, 6, 13, 7'h33));
    issue(enc_r(0, 7, 3, 7, 14, 7'h33));
    issue(enc_i(12'hfff, 2, 2, 15));
    issue(enc_i(12'h0f0, 3, 7, 16));
    issue(enc_i(12'h555, 7, 4, 17));
    issue(enc_i(12'h800, 1, 6, 18));
    issue(enc_i(12'hffe, 2, 3, 19));
    issue({20'habcde, 5'd20, 7'h37});
    issue({20'h00012, 5'd21, 7'h17});
    // Multiplies and MACs, rd written one and two instructions earlier
    issue(enc_r(1, 2, 5, 0, 22, 7'h33));
    issue(enc_r(1, 4, 3, 0, 23, 7'h33));
    issue(enc_i(12'd10, 0, 0, 24));
    issue(enc_r(0, 6, 5, 0, 24, 7'h0b));
    issue(enc_i(12'd3, 0, 0, 25));
    issue(enc_r(0, 1, 1, 0, 26, 7'h33));
    issue(enc_r(0, 6, 6, 0, 25, 7'h0b));
    issue(enc_r(0, 2, 1, 0, 25, 7'h0b));
    issue(enc_r(0, 7, 3, 0, 27, 7'h0b));
    // Branches, taken and not taken
    issue(enc_b(13'd16, 1, 1, 0));
    issue(enc_b(13'd16, 1, 1, 1));
    issue(enc_b(13'h1ff8, 1, 2, 4));
    issue(enc_b(13'd8, 1, 2, 5));
    issue(enc_b(13'd8, 1, 2, 6));
    issue(enc_b(13'd8, 1, 2, 7));
    // Illegal encodings
    issue(enc_i(12'd1, 1, 1, 28));
    issue(enc_r(0, 0, 1, 2, 28, 7'h03));
    issue(enc_r(1, 2, 1, 0, 28, 7'h0b));
    issue(enc_r(1, 2, 1, 4, 28, 7'h33));
    issue(enc_b(13'd8, 1, 1, 2));
    // Random mix of ALU, MUL and MAC on a small register set
    repeat (20) begin
      r   = next_rand();
      rd  = 5'd1 + r[5:3];
      rs1 = r[10:8];
      rs2 = r[13:11];
      case (r[18:16] % 5)
        0: issue(enc_r(0, rs2, rs1, 0, rd, 7'h33));
        1: issue(enc_r(7'h20, rs2, rs1, 0, rd, 7'h33));
        2: issue(enc_r(0, rs2, rs1, 4, rd, 7'h33));
        3: issue(enc_r(1, rs2, rs1, 0, rd, 7'h33));
        default: issue(enc_r(0, rs2, rs1, 0, rd, 7'h0b));
      endcase
    end
    @(negedge clk_i) instr_valid_i = 1'b0;
    repeat (2) @(posedge clk_i);
    for (int i = 1; i < 32; i++) check_value($sformatf("x%0d", i), shadow[i], regs[i]);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
